// ==== hw/fir_pkg.sv ====
//********************************************************************
// fir package
// widths, tap counts, pipeline latency, vector types and the fixed
// coefficient table of the 38-tap symmetric FIR filter
//********************************************************************

`default_nettype none

package fir_pkg;

	//********************************************************************
	// sizes
	//********************************************************************

	// sample, coefficient and internal width
	localparam int DATA_W = 18;

	// filter length and unique coefficient count of the symmetric fold
	localparam int NUM_TAPS = 38;
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// adder tree depth, 19 products need five pairwise levels
	localparam int TREE_LEVELS = $clog2(NUM_UNIQ);

	// pre-add register then product register
	localparam int PAIR_STAGES = 2;

	// enabled edges after the sampling edge until o_out holds the result
	localparam int LATENCY = PAIR_STAGES + TREE_LEVELS;

	//********************************************************************
	// types
	//********************************************************************

	// one sample, coefficient, partial sum or output word
	typedef logic signed [DATA_W-1:0] sample_t;

	// delay line contents, element 0 is the newest sample
	typedef sample_t [NUM_TAPS-1:0] tap_vec_t;

	// products entering the adder tree
	typedef sample_t [NUM_UNIQ-1:0] pair_vec_t;

	//********************************************************************
	// coefficients
	//********************************************************************

	// c[j] weights taps j and NUM_TAPS-1-j
	localparam sample_t COEFFS [NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252
	};

endpackage

`default_nettype wire

// ==== hw/tap_delay_line.sv ====
//********************************************************************
// tap delay line
// shift register of the last 38 samples, all taps visible at once
//********************************************************************

`default_nettype none

module tap_delay_line (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_clk_ena,
	input  fir_pkg::sample_t   i_sample,
	output fir_pkg::tap_vec_t  o_taps
);

	// oldest sample at the top index
	localparam int OLDEST = fir_pkg::NUM_TAPS - 1;

	// shifts on every enabled edge, valid or not, so the history
	// keeps the real sample spacing
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_taps <= '0;
		end else if (i_clk_ena) begin
			// new sample in at element 0, oldest drops out
			o_taps <= {o_taps[OLDEST-1:0], i_sample};
		end
	end

endmodule

`default_nettype wire

// ==== hw/pair_multiply.sv ====
//********************************************************************
// pair multiply
// pre-adds each mirrored tap pair and weights it by its coefficient,
// one register stage for each step
//********************************************************************

`default_nettype none

module pair_multiply (
	input  logic                clk,
	input  logic                i_clk_ena,
	input  fir_pkg::tap_vec_t   i_taps,
	output fir_pkg::pair_vec_t  o_products
);

	// tap j plus tap NUM_TAPS-1-j
	fir_pkg::pair_vec_t pre_sum_q;

	//********************************************************************
	// pre-adders
	//********************************************************************

	for (genvar j = 0; j < fir_pkg::NUM_UNIQ; j++) begin : g_pre_add
		// mirror partner of tap j
		localparam int MIRROR = fir_pkg::NUM_TAPS - 1 - j;

		// sum keeps DATA_W bits and wraps
		always_ff @(posedge clk) begin
			if (i_clk_ena) begin
				pre_sum_q[j] <= i_taps[j] + i_taps[MIRROR];
			end
		end
	end

	//********************************************************************
	// coefficient multipliers
	//********************************************************************

	for (genvar j = 0; j < fir_pkg::NUM_UNIQ; j++) begin : g_mult
		// only the low DATA_W bits of the product are kept
		always_ff @(posedge clk) begin
			if (i_clk_ena) begin
				o_products[j] <= pre_sum_q[j] * fir_pkg::COEFFS[j];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/adder_tree.sv ====
//********************************************************************
// adder tree
// registered pairwise reduction of the products, odd leftovers ride
// a bye register, counts 19 10 5 3 2 1
//********************************************************************

`default_nettype none

module adder_tree (
	input  logic                clk,
	input  logic                i_clk_ena,
	input  fir_pkg::pair_vec_t  i_products,
	output fir_pkg::sample_t    o_sum
);

	//********************************************************************
	// levels
	//********************************************************************

	// level lvl reduces ceil(NUM_UNIQ / 2^(lvl-1)) inputs
	for (genvar lvl = 1; lvl <= fir_pkg::TREE_LEVELS; lvl++) begin : g_level
		localparam int SPAN  = 1 << (lvl - 1);
		localparam int N_IN  = (fir_pkg::NUM_UNIQ + SPAN - 1) / SPAN;
		localparam int N_OUT = (N_IN + 1) / 2;
		localparam int N_ADD = N_IN / 2;

		// inputs of this level
		fir_pkg::sample_t in_d [N_IN];

		// registered outputs of this level
		fir_pkg::sample_t sum_q [N_OUT];

		// first level reads the products, later ones the level below
		if (lvl == 1) begin : g_src
			for (genvar i = 0; i < N_IN; i++) begin : g_in
				assign in_d[i] = i_products[i];
			end
		end else begin : g_src
			for (genvar i = 0; i < N_IN; i++) begin : g_in
				assign in_d[i] = g_level[lvl-1].sum_q[i];
			end
		end

		// neighbouring pairs, wrapping at DATA_W bits
		for (genvar i = 0; i < N_ADD; i++) begin : g_add
			always_ff @(posedge clk) begin
				if (i_clk_ena) begin
					sum_q[i] <= in_d[2*i] + in_d[2*i+1];
				end
			end
		end

		// odd count, last element just takes one cycle
		if (N_IN % 2 == 1) begin : g_bye
			always_ff @(posedge clk) begin
				if (i_clk_ena) begin
					sum_q[N_OUT-1] <= in_d[N_IN-1];
				end
			end
		end
	end

	//********************************************************************
	// output
	//********************************************************************

	// last level has a single element
	assign o_sum = g_level[fir_pkg::TREE_LEVELS].sum_q[0];

endmodule

`default_nettype wire

// ==== hw/valid_pipe.sv ====
//********************************************************************
// valid pipe
// delays i_valid so that o_valid lines up with the adder tree output
//********************************************************************

`default_nettype none

module valid_pipe (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	// bit 0 is taken on the sampling edge together with tap 0,
	// then LATENCY more enabled edges to reach the tree output
	logic [fir_pkg::LATENCY:0] valid_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			// advances only with the datapath, so stalls keep alignment
			valid_q <= {valid_q[fir_pkg::LATENCY-1:0], i_valid};
		end
	end

	assign o_valid = valid_q[fir_pkg::LATENCY];

endmodule

`default_nettype wire

// ==== hw/fir_top.sv ====
//********************************************************************
// fir top
// 38-tap symmetric FIR filter, delay line, folded multipliers,
// pipelined adder tree and a matching valid delay
//********************************************************************

`default_nettype none

module fir_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::sample_t i_in,
	output logic             o_valid,
	output fir_pkg::sample_t o_out
);

	// all taps of the delay line
	fir_pkg::tap_vec_t  taps;

	// one product per unique coefficient
	fir_pkg::pair_vec_t products;

	//********************************************************************
	// datapath
	//********************************************************************

	// sample enters tap 0 on the sampling edge
	tap_delay_line u_tap_delay_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_in),
		.o_taps    (taps)
	);

	// fold mirrored taps, then weight them
	pair_multiply u_pair_multiply (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	// five registered levels down to one sum
	adder_tree u_adder_tree (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	//********************************************************************
	// valid
	//********************************************************************

	// o_valid marks the o_out word that holds a valid input's result
	valid_pipe u_valid_pipe (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

// ==== verification/fir_assertions.sv ====
//********************************************************************
// fir assertions
// concurrent checks on reset, stall and valid timing of the filter
//********************************************************************

`default_nettype none

module fir_assertions (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  logic             i_out_valid,
	input  fir_pkg::sample_t i_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// number of failed properties
	int fail_count = 0;

	// valid pipe is cleared while reset is high
	a_valid_low_in_reset : assert property (
		@(posedge clk) reset |-> !i_out_valid
	) else begin
		$error("o_valid high while reset is asserted");
		fail_count++;
	end

	// a stalled edge leaves both outputs as they were
	a_stall_holds : assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(i_out_valid) && (!i_out_valid || $stable(i_out))
	) else begin
		$error("outputs changed on a stalled edge");
		fail_count++;
	end

	// i_valid comes out LATENCY enabled edges after it was taken
	a_valid_set : assert property (
		@(posedge clk) disable iff (reset)
		(i_clk_ena && i_valid) |=> i_clk_ena[->fir_pkg::LATENCY] ##1 i_out_valid
	) else begin
		$error("valid input did not reach o_valid after the pipeline latency");
		fail_count++;
	end

	a_valid_clear : assert property (
		@(posedge clk) disable iff (reset)
		(i_clk_ena && !i_valid) |=> i_clk_ena[->fir_pkg::LATENCY] ##1 !i_out_valid
	) else begin
		$error("o_valid high for an invalid input");
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== verification/fir_checker.sv ====
//********************************************************************
// fir checker
// reference model of the filter, compares every valid output with
// the expected value and checks that stalls hold the outputs
//********************************************************************

`default_nettype none

module fir_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::sample_t i_in,
	input  logic             i_out_valid,
	input  fir_pkg::sample_t i_out,
	output int               o_checked,
	output int               o_errors,
	output int               o_pending
);

	timeunit 1ns;
	timeprecision 100ps;

	// model history, element 0 is the newest sample
	fir_pkg::sample_t hist [fir_pkg::NUM_TAPS];

	// expected results in output order
	fir_pkg::sample_t expected_q [$];

	int checked_count = 0;
	int error_count = 0;
	int pending_count = 0;

	// outputs and enable seen at the previous edge
	logic             last_ena;
	logic             last_valid;
	fir_pkg::sample_t last_out;

	assign o_checked = checked_count;
	assign o_errors  = error_count;
	assign o_pending = pending_count;

	// y[n] = sum of c[min(j, 37-j)] * x[n-j], wrapped to DATA_W bits
	function automatic fir_pkg::sample_t model_output();
		longint acc;
		int     j;
		int     k;
		acc = 0;
		for (j = 0; j < fir_pkg::NUM_TAPS; j++) begin
			k = (j < fir_pkg::NUM_TAPS - 1 - j) ? j : fir_pkg::NUM_TAPS - 1 - j;
			acc += longint'(fir_pkg::COEFFS[k]) * longint'(hist[j]);
		end
		return fir_pkg::sample_t'(acc);
	endfunction

	//********************************************************************
	// compare and model update
	//********************************************************************

	always @(posedge clk or posedge reset) begin
		fir_pkg::sample_t expected;
		int               j;
		if (reset) begin
			if (i_out_valid === 1'b1) begin
				$display("o_valid is high while reset is asserted");
				error_count++;
			end
			for (j = 0; j < fir_pkg::NUM_TAPS; j++) begin
				hist[j] = '0;
			end
			expected_q.delete();
			last_ena = 1'b1;
			last_valid = 1'b0;
			last_out = '0;
		end else begin
			// previous edge was stalled, nothing may have moved
			if (!last_ena && i_out_valid !== last_valid) begin
				$display("FAILED o_valid hold expected %h actual %h", last_valid, i_out_valid);
				error_count++;
			end
			if (!last_ena && last_valid && i_out !== last_out) begin
				$display("FAILED o_out hold expected %h actual %h", last_out, i_out);
				error_count++;
			end
			if (i_clk_ena) begin
				// a result counts once, on the enabled edge that replaces it
				if (i_out_valid === 1'b1) begin
					if (expected_q.size() == 0) begin
						$display("o_valid is high but no valid input is waiting for a result");
						error_count++;
					end else begin
						expected = expected_q.pop_front();
						if (i_out !== expected) begin
							$display("FAILED o_out expected %h actual %h", expected, i_out);
							error_count++;
						end
						checked_count++;
					end
				end
				// every enabled edge shifts, valid or not
				for (j = fir_pkg::NUM_TAPS - 1; j > 0; j--) begin
					hist[j] = hist[j-1];
				end
				hist[0] = i_in;
				if (i_valid) begin
					expected_q.push_back(model_output());
				end
			end
			last_ena = i_clk_ena;
			last_valid = i_out_valid;
			last_out = i_out;
		end
		pending_count = expected_q.size();
	end

endmodule

`default_nettype wire

// ==== verification/fir_tb.sv ====
//********************************************************************
// fir testbench
// clock, reset and a table of stimulus rows applied to the filter
// while the checker compares the results
//********************************************************************

`default_nettype none

module fir_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;
	localparam int DRAIN_LIMIT = 60;
	localparam logic [31:0] SEED = 32'h8ca3_c670;

	// sample modes
	localparam int MODE_ZERO = 0;
	localparam int MODE_IMPULSE = 1;
	localparam int MODE_STEP = 2;
	localparam int MODE_RANDOM = 3;

	// valid modes
	localparam int VALID_ALL = 0;
	localparam int VALID_NONE = 1;
	localparam int VALID_GAPS = 2;

	// step row constant that makes the sum wrap
	localparam fir_pkg::sample_t STEP_VALUE = 18'sh1_f3a7;

	typedef struct packed {
		logic [8*10-1:0] name;
		int              count;
		int              mode;
		int              valid_mode;
		logic            stalls;
	} test_row_t;

	localparam int NUM_TESTS = 6;

	//********************************************************************
	// stimulus table
	//********************************************************************

	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{"idle", 40, MODE_ZERO, VALID_NONE, 1'b0},
		'{"impulse", 40, MODE_IMPULSE, VALID_ALL, 1'b0},
		'{"random", 200, MODE_RANDOM, VALID_ALL, 1'b0},
		'{"stall", 200, MODE_RANDOM, VALID_ALL, 1'b1},
		'{"valid_gaps", 200, MODE_RANDOM, VALID_GAPS, 1'b0},
		'{"step", 60, MODE_STEP, VALID_ALL, 1'b0}
	};

	logic             clk;
	logic             reset;
	logic             clk_ena;
	logic             valid_in;
	fir_pkg::sample_t sample_in;
	logic             valid_out;
	fir_pkg::sample_t sample_out;
	logic [31:0]      rng;
	int               checked_count;
	int               error_count;
	int               pending_count;

	fir_top dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (clk_ena),
		.i_valid   (valid_in),
		.i_in      (sample_in),
		.o_valid   (valid_out),
		.o_out     (sample_out)
	);

	fir_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (clk_ena),
		.i_valid     (valid_in),
		.i_in        (sample_in),
		.i_out_valid (valid_out),
		.i_out       (sample_out),
		.o_checked   (checked_count),
		.o_errors    (error_count),
		.o_pending   (pending_count)
	);

	bind fir_top fir_assertions u_assertions (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (i_clk_ena),
		.i_valid     (i_valid),
		.i_out_valid (o_valid),
		.i_out       (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// applies one row with optional stall cycles that carry junk inputs
	task automatic apply_row(input test_row_t row, output int valid_inputs);
		int               n;
		int               stalls;
		fir_pkg::sample_t sample;
		logic             valid;
		valid_inputs = 0;
		for (n = 0; n < row.count; n++) begin
			stalls = 0;
			if (row.stalls) begin
				rng = lcg_next(rng);
				stalls = rng[31] ? int'(rng[30:29]) + 1 : 0;
			end
			repeat (stalls) begin
				@(posedge clk);
				rng = lcg_next(rng);
				clk_ena <= 1'b0;
				sample_in <= rng[31:14];
				valid_in <= rng[13];
			end
			rng = lcg_next(rng);
			case (row.mode)
				MODE_IMPULSE: sample = (n == 0) ? 18'sd1 : 18'sd0;
				MODE_STEP: sample = STEP_VALUE;
				MODE_RANDOM: sample = rng[31:14];
				default: sample = '0;
			endcase
			case (row.valid_mode)
				VALID_NONE: valid = 1'b0;
				VALID_GAPS: valid = (rng[13:12] != 2'b00);
				default: valid = 1'b1;
			endcase
			@(posedge clk);
			clk_ena <= 1'b1;
			sample_in <= sample;
			valid_in <= valid;
			if (valid) begin
				valid_inputs++;
			end
		end
	endtask

	// run with enable high until every expected result is out
	task automatic drain(output bit ok);
		int cycles;
		@(posedge clk);
		clk_ena <= 1'b1;
		valid_in <= 1'b0;
		sample_in <= '0;
		cycles = 0;
		@(negedge clk);
		while (pending_count != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		ok = (pending_count == 0);
	endtask

	//********************************************************************
	// main sequence
	//********************************************************************

	initial begin
		int t;
		int checked_before;
		int errors_before;
		int valid_inputs;
		int results;
		int test_errors;
		int failed_tests;
		int assert_fails;
		bit drained;
		bit timed_out;
		reset = 1'b1;
		clk_ena = 1'b1;
		valid_in = 1'b0;
		sample_in = '0;
		rng = SEED;
		failed_tests = 0;
		timed_out = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
			@(negedge clk);
			checked_before = checked_count;
			errors_before = error_count;
			apply_row(TESTS[t], valid_inputs);
			drain(drained);
			if (!drained) begin
				$display("test %0s: outputs did not drain within %0d cycles",
					TESTS[t].name, DRAIN_LIMIT);
				timed_out = 1'b1;
			end else begin
				results = checked_count - checked_before;
				test_errors = error_count - errors_before;
				if (results != valid_inputs) begin
					$display("test %0s: %0d results came out for %0d valid inputs",
						TESTS[t].name, results, valid_inputs);
					failed_tests++;
				end else if (test_errors != 0) begin
					failed_tests++;
				end
				$display("test %0s: %0d valid inputs, %0d results, %0d errors",
					TESTS[t].name, valid_inputs, results, test_errors);
			end
		end
		assert_fails = dut.u_assertions.fail_count;
		$display("tests %0d, failed %0d, results %0d, errors %0d, assertion failures %0d",
			NUM_TESTS, failed_tests, checked_count, error_count, assert_fails);
		if (!timed_out && failed_tests == 0 && error_count == 0 && assert_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/fir_pkg.sv
hw/tap_delay_line.sv
hw/pair_multiply.sv
hw/adder_tree.sv
hw/valid_pipe.sv
hw/fir_top.sv
verification/fir_assertions.sv
verification/fir_checker.sv
verification/fir_tb.sv
